//--- Makefile
# Verilator build and run for the forthAlu testbench

.PHONY: all lint clean

all:
	verilator --binary --timing -f forthAlu.f --top-module aluCoreTb -o aluCoreSim
	./obj_dir/aluCoreSim | tee sim.log
	grep -qx "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f forthAlu.f --top-module aluCore

clean:
	rm -rf obj_dir sim.log

//--- dv/aluCoreModel.svh
`ifndef ALU_CORE_MODEL_SVH
`define ALU_CORE_MODEL_SVH

// Expected register file and condition codes
logic [DataWidth-1:0]    modelRegs [RegCount];
logic [FlagWidth-1:0]    modelFlags;
logic [31:0]             randState;

// Write expected for the word last passed to modelStep
logic                    expWen;
logic [RegAddrWidth-1:0] expAddr;
logic [DataWidth-1:0]    expData;

function automatic logic [31:0] nextRand();
	randState = randState * 32'd1664525 + 32'd1013904223;  // Common 32-bit LCG constants
	return randState;
endfunction

function automatic void modelReset();
	for (int i = 0; i < RegCount; i++) begin
		modelRegs[i] = '0;
	end
	modelFlags = '0;
endfunction

function automatic void modelStep(input instrT w);
	logic [DataWidth-1:0]    a;
	logic [DataWidth-1:0]    b;
	logic [DataWidth-1:0]    res;
	logic                    carry;
	logic [RegAddrWidth-1:0] dest;
	expWen  = 1'b0;
	expAddr = '0;
	expData = '0;
	if (w.group != GroupAlu) begin
		return;  // Other groups leave everything alone
	end
	dest = w.payload.regs.argA[RegAddrWidth-1:0];
	a    = modelRegs[dest];
	b    = modelRegs[w.payload.regs.argB[RegAddrWidth-1:0]];
	if (w.mode == ModeRegU4) begin
		b = DataWidth'(w.payload.regs.argB);
	end else if (w.mode == ModeAccU8) begin
		// Accumulator form works on R0 with the whole low byte
		dest = '0;
		a    = modelRegs[0];
		b    = DataWidth'(w.payload.imm8);
	end
	carry = 1'b0;
	case (w.op)
		OpMov:   res = b;
		OpAdd:   {carry, res} = {1'b0, a} + {1'b0, b};
		OpSub: begin
			res   = a - b;
			carry = a < b;  // Borrow
		end
		OpAnd:   res = a & b;
		OpOr:    res = a | b;
		OpXor:   res = a ^ b;
		OpNot:   res = ~b;
		OpShr: begin
			res   = a >> 1;
			carry = a[0];
		end
		default: res = '0;
	endcase
	if (w.op != OpMov) begin
		modelFlags = {res == '0, res[DataWidth-1], carry};
	end
	if (w.mode != ModeCmpRegReg) begin
		modelRegs[dest] = res;
		expWen          = 1'b1;
		expAddr         = dest;
		expData         = res;
	end
endfunction

`endif

//--- dv/aluCoreTb.sv
`timescale 1ns/100ps

module aluCoreTb;
	import forthAluPkg::*;

	localparam logic [31:0] Seed = 32'haa7b66f4;
	localparam int TotalWords = 500;
	localparam int CycleLimit = TotalWords * 12 + 100;

	logic                    CLK;
	logic                    arstN;
	logic                    instrReq;
	logic [DataWidth-1:0]    instr;
	logic                    instrAck;
	logic                    wrEn;
	logic [RegAddrWidth-1:0] wrAddr;
	logic [DataWidth-1:0]    wrData;
	logic [FlagWidth-1:0]    flags;

	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int testStartErrors = 0;

	`include "aluCoreModel.svh"

	aluCore uut (
		.CLK      (CLK),
		.arstN    (arstN),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.wrEn     (wrEn),
		.wrAddr   (wrAddr),
		.wrData   (wrData),
		.flags    (flags)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: run still going after %0d cycles", CycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error: %s is %h, expected %h at cycle %0d", name, got, exp, cycleCount);
		end
	endtask

	task automatic noteFailure(input string what);
		errorCount++;
		$display("%s (cycle %0d)", what, cycleCount);
	endtask

	task automatic endTest(input string name);
		int errs;
		errs = errorCount - testStartErrors;
		testCount++;
		$display("Test %0d %s: %s, %0d errors", testCount, name,
			(errs == 0) ? "ok" : "FAILED", errs);
		testStartErrors = errorCount;
	endtask

	// One full four-phase handshake where the host lets go hold cycles after the ack
	task automatic sendWord(input instrT w, input int hold);
		logic [FlagWidth-1:0] flagsExp;
		int waitCnt;
		int sinceAccept;
		modelStep(w);
		flagsExp = modelFlags;
		@(posedge CLK);
		instrReq <= 1'b1;
		instr    <= w;
		waitCnt = 0;
		do begin
			@(negedge CLK);
			waitCnt++;
			checkEq("wrEn", wrEn, 1'b0);  // Nothing may still be in flight
		end while (!instrAck && waitCnt < 16);
		if (!instrAck) begin
			noteFailure("instrAck never rose");
			return;
		end
		sinceAccept = 0;
		while (sinceAccept < 3 || instrReq || instrAck) begin
			@(posedge CLK);
			if (sinceAccept >= hold) begin
				instrReq <= 1'b0;
			end
			@(negedge CLK);
			sinceAccept++;
			// COMMIT is the third cycle after the accepting edge
			if (sinceAccept == 2) begin
				if (expWen && !wrEn) begin
					noteFailure("no write seen after accepted instruction");
				end else begin
					checkEq("wrEn", wrEn, expWen);
					if (wrEn) begin
						checkEq("wrAddr", wrAddr, expAddr);
						checkEq("wrData", wrData, expData);
					end
				end
			end else begin
				checkEq("wrEn", wrEn, 1'b0);  // A late write means a second accept
			end
			if (sinceAccept == 3) begin
				checkEq("flags", flags, flagsExp);
			end
			if (instrReq && !instrAck) begin
				noteFailure("instrAck fell while instrReq was still high");
			end
			if (sinceAccept > hold + 8) begin
				noteFailure("instrAck never fell after instrReq was dropped");
				break;
			end
		end
	endtask

	initial begin
		instrT       w;
		logic [31:0] r;
		arstN     = 1'b0;
		instrReq  = 1'b0;
		instr     = '0;
		randState = Seed;
		modelReset();
		repeat (4) @(posedge CLK);
		arstN <= 1'b1;

		@(negedge CLK);
		checkEq("instrAck", instrAck, 1'b0);
		checkEq("wrEn", wrEn, 1'b0);
		checkEq("flags", flags, 3'b000);
		endTest("reset state");

		repeat (200) begin
			r = nextRand();
			w = r[31:16];
			w.group = GroupAlu;
			w.op    = {1'b0, w.op[2:0]};
			w.mode  = {1'b0, w.mode[0]};  // RegReg or RegU4
			sendWord(w, 0);
		end
		endTest("register-register operations");

		repeat (100) begin
			r = nextRand();
			w = r[31:16];
			w.group = GroupAlu;
			w.op    = {1'b0, w.op[2:0]};
			w.mode  = ModeAccU8;
			sendWord(w, 0);
		end
		endTest("accumulator immediate");

		// Every op code and mode, compare and mov included
		repeat (100) begin
			r = nextRand();
			w = r[31:16];
			w.group = GroupAlu;
			sendWord(w, 0);
		end
		endTest("flags");

		repeat (100) begin
			r = nextRand();
			w = r[31:16];
			sendWord(w, int'(r[10:8]) % 6);
		end
		endTest("foreign groups and handshake");

		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- forthAlu.f
+incdir+dv
hw/forthAluPkg.sv
hw/phaseBus.sv
hw/ctrlBus.sv
hw/instructionPhaseDecoder.sv
hw/aluGroupDecoder.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/aluCore.sv
dv/aluCoreTb.sv

//--- hw/aluCore.sv
`timescale 1ns/100ps

module aluCore (
	input  logic                                 CLK,
	input  logic                                 arstN,
	input  logic                                 instrReq,
	input  logic [forthAluPkg::DataWidth-1:0]    instr,
	output logic                                 instrAck,
	output logic                                 wrEn,
	output logic [forthAluPkg::RegAddrWidth-1:0] wrAddr,
	output logic [forthAluPkg::DataWidth-1:0]    wrData,
	output logic [forthAluPkg::FlagWidth-1:0]    flags
);
	import forthAluPkg::*;

	logic [DataWidth-1:0] rdA;
	logic [DataWidth-1:0] rdB;
	logic [DataWidth-1:0] result;

	phaseBus phaseIf ();
	ctrlBus  ctrlIf ();

	instructionPhaseDecoder sequencer (
		.CLK      (CLK),
		.arstN    (arstN),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.phase    (phaseIf)
	);

	aluGroupDecoder decoder (
		.CLK   (CLK),
		.arstN (arstN),
		.phase (phaseIf),
		.ctrl  (ctrlIf)
	);

	registerFile regFile (
		.CLK    (CLK),
		.arstN  (arstN),
		.ctrl   (ctrlIf),
		.wrData (result),
		.rdA    (rdA),
		.rdB    (rdB)
	);

	aluUnit alu (
		.CLK    (CLK),
		.arstN  (arstN),
		.ctrl   (ctrlIf),
		.rdA    (rdA),
		.rdB    (rdB),
		.result (result),
		.flags  (flags)
	);

	// Commit-time write seen from outside
	assign wrEn   = ctrlIf.regWen;
	assign wrAddr = ctrlIf.regWAddr;
	assign wrData = result;

endmodule

//--- hw/aluGroupDecoder.sv
`timescale 1ns/100ps

module aluGroupDecoder (
	input  logic CLK,
	input  logic arstN,
	phaseBus.dec phase,
	ctrlBus.dec  ctrl
);
	import forthAluPkg::*;

	instrT                   ir;
	logic                    isAlu;
	logic                    isAcc;
	logic                    isCmp;
	logic [RegAddrWidth-1:0] addrA;
	logic [RegAddrWidth-1:0] addrB;
	logic [DataWidth-1:0]    immExt;

	// Held from DECODE through COMMIT
	logic aluInstr;
	logic readB;
	logic writeBack;
	logic flagLoad;

	assign ir    = phase.instr;
	assign isAlu = ir.group == GroupAlu;
	assign isAcc = ir.mode == ModeAccU8;
	assign isCmp = ir.mode == ModeCmpRegReg;

	// Payload view depends on the mode
	always_comb begin
		if (isAcc) begin
			addrA  = '0;  // Accumulator is R0
			addrB  = '0;
			immExt = {{(DataWidth-PayloadWidth){1'b0}}, ir.payload.imm8};
		end else begin
			// Only the low three bits of each nibble name a register
			addrA  = ir.payload.regs.argA[RegAddrWidth-1:0];
			addrB  = ir.payload.regs.argB[RegAddrWidth-1:0];
			immExt = {{(DataWidth-ArgWidth){1'b0}}, ir.payload.regs.argB};
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			aluInstr      <= 1'b0;
			readB         <= 1'b0;
			writeBack     <= 1'b0;
			flagLoad      <= 1'b0;
			ctrl.regAAddr <= '0;
			ctrl.regBAddr <= '0;
			ctrl.regWAddr <= '0;
			ctrl.aluOp    <= OpMov;
			ctrl.srcBSel  <= 1'b0;
			ctrl.imm      <= '0;
		end else if (phase.decode) begin
			aluInstr      <= isAlu;
			readB         <= (ir.mode == ModeRegReg) || isCmp;
			writeBack     <= !isCmp;
			flagLoad      <= ir.op != OpMov;  // Mov keeps the flags
			ctrl.regAAddr <= addrA;
			ctrl.regBAddr <= addrB;
			ctrl.regWAddr <= addrA;           // Destination is always A
			ctrl.aluOp    <= ir.op;
			ctrl.srcBSel  <= (ir.mode == ModeRegU4) || isAcc;
			ctrl.imm      <= immExt;
		end else if (phase.fetch) begin
			aluInstr <= 1'b0;  // Nothing in flight while waiting
		end
	end

	// Other groups step through with every enable low
	assign ctrl.regAEn = phase.execute & aluInstr;
	assign ctrl.regBEn = phase.execute & aluInstr & readB;
	assign ctrl.regWen = phase.commit & aluInstr & writeBack;
	assign ctrl.cclLd  = phase.commit & aluInstr & flagLoad;

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
	input  logic                              CLK,
	input  logic                              arstN,
	ctrlBus.alu                               ctrl,
	input  logic [forthAluPkg::DataWidth-1:0] rdA,
	input  logic [forthAluPkg::DataWidth-1:0] rdB,
	output logic [forthAluPkg::DataWidth-1:0] result,
	output logic [forthAluPkg::FlagWidth-1:0] flags
);
	import forthAluPkg::*;

	logic [DataWidth-1:0] opB;
	logic [DataWidth:0]   wide;  // Carry or borrow on top
	logic [FlagWidth-1:0] nextFlags;
	logic [FlagWidth-1:0] pendFlags;

	assign opB = ctrl.srcBSel ? ctrl.imm : rdB;

	always_comb begin
		case (ctrl.aluOp)
			OpMov:   wide = {1'b0, opB};
			OpAdd:   wide = {1'b0, rdA} + {1'b0, opB};
			OpSub:   wide = {1'b0, rdA} - {1'b0, opB};  // Top bit set on borrow
			OpAnd:   wide = {1'b0, rdA & opB};
			OpOr:    wide = {1'b0, rdA | opB};
			OpXor:   wide = {1'b0, rdA ^ opB};
			OpNot:   wide = {1'b0, ~opB};
			OpShr:   wide = {rdA[0], 1'b0, rdA[DataWidth-1:1]};
			default: wide = '0;
		endcase
	end

	// C stays clear unless the op drives the top bit
	always_comb begin
		nextFlags        = '0;
		nextFlags[FlagZ] = wide[DataWidth-1:0] == '0;
		nextFlags[FlagN] = wide[DataWidth-1];
		nextFlags[FlagC] = wide[DataWidth];
	end

	// Result and pending flags captured at the end of EXECUTE
	always_ff @(posedge CLK) begin
		if (ctrl.regAEn) begin
			result    <= wide[DataWidth-1:0];
			pendFlags <= nextFlags;
		end
	end

	// Condition-code latch
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (ctrl.cclLd) begin
			flags <= pendFlags;
		end
	end

endmodule

//--- hw/ctrlBus.sv
`timescale 1ns/100ps

interface ctrlBus;
	import forthAluPkg::*;

	logic                    regAEn;
	logic                    regBEn;
	logic                    regWen;
	logic [RegAddrWidth-1:0] regAAddr;
	logic [RegAddrWidth-1:0] regBAddr;
	logic [RegAddrWidth-1:0] regWAddr;
	logic [OpWidth-1:0]      aluOp;
	logic                    srcBSel;  // High picks imm for operand B
	logic [DataWidth-1:0]    imm;
	logic                    cclLd;

	modport dec (
		output regAEn, regBEn, regWen,
		output regAAddr, regBAddr, regWAddr,
		output aluOp, srcBSel, imm, cclLd
	);

	modport rf (
		input regAEn, regBEn, regWen,
		input regAAddr, regBAddr, regWAddr
	);

	// regAEn marks the execute cycle for the ALU
	modport alu (
		input regAEn,
		input aluOp, srcBSel, imm, cclLd
	);
endinterface

//--- hw/forthAluPkg.sv
package forthAluPkg;

	localparam int DataWidth    = 16;
	localparam int RegCount     = 8;
	localparam int RegAddrWidth = 3;
	localparam int FlagWidth    = 3;

	// Instruction field widths
	localparam int GroupWidth   = 2;
	localparam int OpWidth      = 4;
	localparam int ModeWidth    = 2;
	localparam int ArgWidth     = 4;
	localparam int PayloadWidth = 8;

	// Flag bit positions, ordered Z N C from the top
	localparam int FlagZ = 2;
	localparam int FlagN = 1;
	localparam int FlagC = 0;

	localparam logic [GroupWidth-1:0] GroupAlu = 2'b01;

	localparam logic [OpWidth-1:0] OpMov = 4'h0;  // B
	localparam logic [OpWidth-1:0] OpAdd = 4'h1;  // A + B, carry out
	localparam logic [OpWidth-1:0] OpSub = 4'h2;  // A - B, C on borrow
	localparam logic [OpWidth-1:0] OpAnd = 4'h3;
	localparam logic [OpWidth-1:0] OpOr  = 4'h4;
	localparam logic [OpWidth-1:0] OpXor = 4'h5;
	localparam logic [OpWidth-1:0] OpNot = 4'h6;  // ~B
	localparam logic [OpWidth-1:0] OpShr = 4'h7;  // A >> 1, C gets bit 0

	localparam logic [ModeWidth-1:0] ModeRegReg    = 2'b00;
	localparam logic [ModeWidth-1:0] ModeRegU4     = 2'b01;
	localparam logic [ModeWidth-1:0] ModeAccU8     = 2'b10;
	localparam logic [ModeWidth-1:0] ModeCmpRegReg = 2'b11;  // Flags only

	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		COMMIT
	} phaseT;

	typedef struct packed {
		logic [ArgWidth-1:0] argA;
		logic [ArgWidth-1:0] argB;
	} regsT;

	// Low byte seen as two register nibbles or as one immediate
	typedef union packed {
		regsT                    regs;
		logic [PayloadWidth-1:0] imm8;
	} payloadT;

	typedef struct packed {
		logic [GroupWidth-1:0] group;
		logic [OpWidth-1:0]    op;
		logic [ModeWidth-1:0]  mode;
		payloadT               payload;
	} instrT;

endpackage

//--- hw/instructionPhaseDecoder.sv
`timescale 1ns/100ps

module instructionPhaseDecoder (
	input  logic              CLK,
	input  logic              arstN,
	input  logic              instrReq,
	input  forthAluPkg::instrT instr,
	output logic              instrAck,
	phaseBus.seq              phase
);
	import forthAluPkg::*;

	phaseT state;
	logic  accept;
	logic  ackReg;

	// New word only when idle and the previous handshake has closed
	assign accept = (state == FETCH) && instrReq && !ackReg;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= FETCH;
		end else begin
			case (state)
				FETCH: begin
					if (accept) begin
						state <= DECODE;
					end
				end
				DECODE:  state <= EXECUTE;
				EXECUTE: state <= COMMIT;
				default: state <= FETCH;  // COMMIT wraps round
			endcase
		end
	end

	// Four-phase ack, independent of the phase stepping
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ackReg <= 1'b0;
		end else if (accept) begin
			ackReg <= 1'b1;
		end else if (!instrReq) begin
			ackReg <= 1'b0;  // Host has let go
		end
	end

	assign instrAck = ackReg;

	always_ff @(posedge CLK) begin
		if (accept) begin
			phase.instr <= instr;
		end
	end

	assign phase.fetch   = state == FETCH;
	assign phase.decode  = state == DECODE;
	assign phase.execute = state == EXECUTE;
	assign phase.commit  = state == COMMIT;

endmodule

//--- hw/phaseBus.sv
`timescale 1ns/100ps

interface phaseBus;
	import forthAluPkg::*;

	// One-hot phase strobes
	logic fetch;
	logic decode;
	logic execute;
	logic commit;

	instrT instr;  // Word held from acceptance until the next one

	modport seq (
		output fetch,
		output decode,
		output execute,
		output commit,
		output instr
	);

	modport dec (
		input fetch,
		input decode,
		input execute,
		input commit,
		input instr
	);
endinterface

//--- hw/registerFile.sv
`timescale 1ns/100ps

module registerFile (
	input  logic                              CLK,
	input  logic                              arstN,
	ctrlBus.rf                                ctrl,
	input  logic [forthAluPkg::DataWidth-1:0] wrData,
	output logic [forthAluPkg::DataWidth-1:0] rdA,
	output logic [forthAluPkg::DataWidth-1:0] rdB
);
	import forthAluPkg::*;

	logic [DataWidth-1:0] regs [RegCount];

	// Single write port, used at COMMIT
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regs <= '{default: '0};
		end else if (ctrl.regWen) begin
			regs[ctrl.regWAddr] <= wrData;
		end
	end

	// Read ports idle at zero outside EXECUTE
	always_comb begin
		if (ctrl.regAEn) begin
			rdA = regs[ctrl.regAAddr];
		end else begin
			rdA = '0;
		end
	end

	always_comb begin
		if (ctrl.regBEn) begin
			rdB = regs[ctrl.regBAddr];
		end else begin
			rdB = '0;
		end
	end

endmodule
